//--- all.f
sdr_types_pkg.sv
sdr_regmap_pkg.sv
rx_pair_if.sv
frontend_switch.sv
vita_timer.sv
misc_settings.sv
readback_mux.sv
sdr_core_top.sv
tb_sdr_core.sv

//--- frontend_switch.sv
// Outputs registered one cycle behind the ADC words; a swap write shows from the second cycle
`timescale 1ns/1ps

module frontend_switch #(
   parameter int BASE = sdr_regmap_pkg::SR_RX_FRONT_SW
) (
   input  logic                     dsp_clk,
   input  logic                     por_rst,
   input  logic                     set_stb_i,
   input  sdr_types_pkg::set_addr_t set_addr_i,
   input  sdr_types_pkg::set_data_t set_data_i,
   input  sdr_types_pkg::adc_word_t adc0_a_i,
   input  sdr_types_pkg::adc_word_t adc0_b_i,
   input  sdr_types_pkg::adc_word_t adc1_a_i,
   input  sdr_types_pkg::adc_word_t adc1_b_i,
   input  logic                     run0_i,
   input  logic                     run1_i,
   rx_pair_if.source                rx_o
);
   import sdr_types_pkg::*;

   localparam set_addr_t SWAP_ADDR = set_addr_t'(BASE);

   logic swap;

   // Put the ADC word in the top bits of a sample
   function automatic sample_t left_justify(input adc_word_t w);
      return {w, {(SAMPLE_W - ADC_W){1'b0}}};
   endfunction

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         swap <= 1'b0;
      end else if (set_stb_i && (set_addr_i == SWAP_ADDR)) begin
         swap <= set_data_i[0];
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Output pair, a = I and b = Q
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (swap) begin
         rx_o.ch0_i <= left_justify(adc1_a_i);
         rx_o.ch0_q <= left_justify(adc1_b_i);
         rx_o.ch1_i <= left_justify(adc0_a_i);
         rx_o.ch1_q <= left_justify(adc0_b_i);
      end else begin
         rx_o.ch0_i <= left_justify(adc0_a_i);
         rx_o.ch0_q <= left_justify(adc0_b_i);
         rx_o.ch1_i <= left_justify(adc1_a_i);
         rx_o.ch1_q <= left_justify(adc1_b_i);
      end
   end

   // Run flags follow their channel
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rx_o.run0 <= 1'b0;
         rx_o.run1 <= 1'b0;
      end else begin
         rx_o.run0 <= swap ? run1_i : run0_i;
         rx_o.run1 <= swap ? run0_i : run1_i;
      end
   end

endmodule

//--- misc_settings.sv
// Misc control registers; leds_o is combinational from the registers and the switched run flags
`timescale 1ns/1ps

module misc_settings #(
   parameter int BASE = sdr_regmap_pkg::SR_MISC
) (
   input  logic                     dsp_clk,
   input  logic                     por_rst,
   input  logic                     set_stb_i,
   input  sdr_types_pkg::set_addr_t set_addr_i,
   input  sdr_types_pkg::set_data_t set_data_i,
   rx_pair_if.sink                  rx_i,
   output logic [7:0]               leds_o,
   output logic                     div_sw1_o,
   output logic                     div_sw2_o,
   output logic                     phy_reset_n_o
);
   import sdr_types_pkg::*;
   import sdr_regmap_pkg::*;

   localparam set_addr_t ADDR_LED_SW  = set_addr_t'(BASE + MISC_LED_SW);
   localparam set_addr_t ADDR_PHY_RST = set_addr_t'(BASE + MISC_PHY_RESET);
   localparam set_addr_t ADDR_LED_SRC = set_addr_t'(BASE + MISC_LED_SRC);
   localparam set_addr_t ADDR_DIVSW1  = set_addr_t'(SR_DIVSW);
   localparam set_addr_t ADDR_DIVSW2  = set_addr_t'(SR_DIVSW + 1);

   logic [7:0] led_sw;
   logic [7:0] led_src;    // 1 = hardware, 0 = software
   logic [7:0] led_hw;
   logic       phy_reset;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw    <= LED_SW_RESET;
         led_src   <= LED_SRC_RESET;
         phy_reset <= PHY_RESET_RESET;
         div_sw1_o <= DIVSW_RESET;
         div_sw2_o <= DIVSW_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_LED_SW:  led_sw    <= set_data_i[7:0];
            ADDR_PHY_RST: phy_reset <= set_data_i[0];
            ADDR_LED_SRC: led_src   <= set_data_i[7:0];
            ADDR_DIVSW1:  div_sw1_o <= set_data_i[0];
            ADDR_DIVSW2:  div_sw2_o <= set_data_i[0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////
   // LED mux
   ////////////////////////////////////////////////////////////////////
   assign led_hw = {4'b0000, rx_i.run0, 1'b0, rx_i.run1, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign phy_reset_n_o = ~phy_reset;   // PHY pin is active low

endmodule

//--- readback_mux.sv
// Registered status readback; rb_addr_i is a level and rb_data_o follows one cycle later
`timescale 1ns/1ps

module readback_mux (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic [3:0]                rb_addr_i,
   rx_pair_if.sink                   rx_i,
   input  sdr_types_pkg::vita_time_t time_i,
   input  sdr_types_pkg::vita_time_t time_pps_i,
   input  logic                      button_i,
   input  logic                      clk_status_i,
   output logic [31:0]               rb_data_o
);
   import sdr_types_pkg::*;
   import sdr_regmap_pkg::*;

   logic [31:0] rb_word;
   logic [31:0] status_word;

   assign status_word = {18'd0, button_i, 1'b0, clk_status_i, 11'd0};

   always_comb begin
      case (rb_word_e'(rb_addr_i))
         RB_ADC0:    rb_word = {rx_i.ch0_i[SAMPLE_W-1 -: 16], rx_i.ch0_q[SAMPLE_W-1 -: 16]};
         RB_ADC1:    rb_word = {rx_i.ch1_i[SAMPLE_W-1 -: 16], rx_i.ch1_q[SAMPLE_W-1 -: 16]};
         RB_TIME_HI: rb_word = time_i[63:32];
         RB_TIME_LO: rb_word = time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_STATUS:  rb_word = status_word;
         RB_PPS_HI:  rb_word = time_pps_i[63:32];
         RB_PPS_LO:  rb_word = time_pps_i[31:0];
         default:    rb_word = 32'd0;   // Spare words
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= 32'd0;
      end else begin
         rb_data_o <= rb_word;
      end
   end

endmodule

//--- rx_pair_if.sv
// Both switched rx channels after the front-end swap; no handshake, new data every dsp_clk
`timescale 1ns/1ps

interface rx_pair_if;
   import sdr_types_pkg::*;

   sample_t ch0_i;
   sample_t ch0_q;
   sample_t ch1_i;
   sample_t ch1_q;
   logic    run0;
   logic    run1;

   modport source (output ch0_i, ch0_q, ch1_i, ch1_q, run0, run1);

   modport sink   (input ch0_i, ch0_q, ch1_i, ch1_q, run0, run1);

endinterface

//--- sdr_core_top.sv
// Single dsp_clk domain; run flags come from outside and the settings bus has no handshake
`timescale 1ns/1ps

module sdr_core_top (
   input  logic                     dsp_clk,
   input  logic                     por_rst,
   // Settings bus
   input  logic                     set_stb_i,
   input  sdr_types_pkg::set_addr_t set_addr_i,
   input  sdr_types_pkg::set_data_t set_data_i,
   // ADC and run flags
   input  sdr_types_pkg::adc_word_t adc0_a_i,
   input  sdr_types_pkg::adc_word_t adc0_b_i,
   input  sdr_types_pkg::adc_word_t adc1_a_i,
   input  sdr_types_pkg::adc_word_t adc1_b_i,
   input  logic                     run_rx0_i,
   input  logic                     run_rx1_i,
   // Timing and status
   input  logic                     pps_i,
   input  logic                     button_i,
   input  logic                     clk_status_i,
   input  logic [3:0]               rb_addr_i,
   // Switched samples
   output sdr_types_pkg::sample_t   rx0_i_o,
   output sdr_types_pkg::sample_t   rx0_q_o,
   output sdr_types_pkg::sample_t   rx1_i_o,
   output sdr_types_pkg::sample_t   rx1_q_o,
   output logic                     run0_o,
   output logic                     run1_o,
   // Misc
   output logic [7:0]               leds_o,
   output logic                     div_sw1_o,
   output logic                     div_sw2_o,
   output logic                     phy_reset_n_o,
   output logic                     pps_int_o,
   output logic [31:0]              rb_data_o
);
   import sdr_types_pkg::*;
   import sdr_regmap_pkg::*;

   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   rx_pair_if rx_pair ();

   ////////////////////////////////////////////////////////////////////
   // Sample path
   ////////////////////////////////////////////////////////////////////
   frontend_switch #(.BASE(SR_RX_FRONT_SW)) u_frontend_switch (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .adc0_a_i   (adc0_a_i),
      .adc0_b_i   (adc0_b_i),
      .adc1_a_i   (adc1_a_i),
      .adc1_b_i   (adc1_b_i),
      .run0_i     (run_rx0_i),
      .run1_i     (run_rx1_i),
      .rx_o       (rx_pair.source)
   );

   assign rx0_i_o = rx_pair.ch0_i;
   assign rx0_q_o = rx_pair.ch0_q;
   assign rx1_i_o = rx_pair.ch1_i;
   assign rx1_q_o = rx_pair.ch1_q;
   assign run0_o  = rx_pair.run0;
   assign run1_o  = rx_pair.run1;

   // Time base
   vita_timer #(.BASE(SR_TIME64)) u_vita_timer (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .pps_i      (pps_i),
      .time_o     (vita_time),
      .time_pps_o (vita_time_pps),
      .pps_int_o  (pps_int_o)
   );

   misc_settings #(.BASE(SR_MISC)) u_misc_settings (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .rx_i          (rx_pair.sink),
      .leds_o        (leds_o),
      .div_sw1_o     (div_sw1_o),
      .div_sw2_o     (div_sw2_o),
      .phy_reset_n_o (phy_reset_n_o)
   );

   ////////////////////////////////////////////////////////////////////
   // Status readback
   ////////////////////////////////////////////////////////////////////
   readback_mux u_readback_mux (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .rb_addr_i    (rb_addr_i),
      .rx_i         (rx_pair.sink),
      .time_i       (vita_time),
      .time_pps_i   (vita_time_pps),
      .button_i     (button_i),
      .clk_status_i (clk_status_i),
      .rb_data_o    (rb_data_o)
   );

endmodule

//--- sdr_regmap_pkg.sv
// Settings bus map and readback words; register blocks must not overlap when bases are moved
package sdr_regmap_pkg;

   ////////////////////////////////////////////////////////////////////
   // Settings register bases
   ////////////////////////////////////////////////////////////////////
   localparam int SR_MISC        = 0;     // 7 regs
   localparam int SR_TIME64      = 10;    // 3 regs
   localparam int SR_RX_FRONT_SW = 176;   // 1 reg
   localparam int SR_DIVSW       = 180;   // 2 regs

   // Offsets inside the misc block
   localparam int MISC_LED_SW    = 3;
   localparam int MISC_PHY_RESET = 4;
   localparam int MISC_LED_SRC   = 6;

   // Offsets inside the time block
   localparam int TIME_HI   = 0;
   localparam int TIME_LO   = 1;
   localparam int TIME_CTRL = 2;   // Bit 0 picks load now or at PPS

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = {16'd8, 16'd2};   // Major, minor

   // Reset values
   localparam logic [7:0] LED_SRC_RESET   = 8'b0001_1110;
   localparam logic [7:0] LED_SW_RESET    = 8'h00;
   localparam logic       DIVSW_RESET     = 1'b1;
   localparam logic       PHY_RESET_RESET = 1'b0;

   // Readback words, unnamed ones read as zero
   typedef enum logic [3:0] {
      RB_ADC0    = 4'd6,
      RB_ADC1    = 4'd7,
      RB_TIME_HI = 4'd10,
      RB_TIME_LO = 4'd11,
      RB_COMPAT  = 4'd12,
      RB_STATUS  = 4'd13,
      RB_PPS_HI  = 4'd14,
      RB_PPS_LO  = 4'd15
   } rb_word_e;

endpackage

//--- sdr_types_pkg.sv
// Widths and types shared by the whole core; samples are ADC words left-justified in 24 bits
package sdr_types_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////
   localparam int ADC_W    = 12;   // Raw ADC word
   localparam int SAMPLE_W = 24;   // Front-end sample
   localparam int TIME_W   = 64;   // VITA tick counter

   // Sample path
   typedef logic [ADC_W-1:0]    adc_word_t;
   typedef logic [SAMPLE_W-1:0] sample_t;   // ADC word on top, zeros below

   typedef logic [TIME_W-1:0]   vita_time_t;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Time load modes
   typedef enum logic [1:0] {
      LOAD_IDLE   = 2'd0,   // Nothing armed
      LOAD_NOW    = 2'd1,   // Load on the strobe edge
      LOAD_AT_PPS = 2'd2    // Load on the next PPS edge
   } time_load_e;

endpackage

//--- tb_sdr_core.sv
// Random-stimulus testbench with a cycle model; stops at the first mismatch, PPS wait is bounded
`timescale 1ns/1ps

module tb_sdr_core;
   import sdr_types_pkg::*;
   import sdr_regmap_pkg::*;

   localparam int PPS_TIMEOUT = 20;          // Cycles to wait for pps_int_o
   localparam int TIME_BASE   = SR_TIME64;

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   adc_word_t   adc0_a, adc0_b, adc1_a, adc1_b;
   logic        run_rx0, run_rx1;
   logic        pps, button, clk_status;
   logic [3:0]  rb_addr;
   sample_t     rx0_i, rx0_q, rx1_i, rx1_q;
   logic        run0, run1;
   logic [7:0]  leds;
   logic        div_sw1, div_sw2, phy_reset_n, pps_int;
   logic [31:0] rb_data;

   logic        checking;
   logic        stim_on;
   integer      seed = 32'h714c;
   logic [31:0] stim_rnd;
   logic        time_ctrl_wr;

   // Reference model state
   logic        m_swap;
   sample_t     m_rx0_i, m_rx0_q, m_rx1_i, m_rx1_q;
   logic        m_run0, m_run1;
   logic [7:0]  m_led_sw, m_led_src;
   logic        m_div1, m_div2, m_phy;
   set_data_t   m_hi, m_lo;
   vita_time_t  m_time, m_time_pps;
   logic [2:0]  m_pps_pipe;       // Two sync flops, then the edge flop
   logic        m_pps_edge, m_pps_int, m_armed;

   sdr_core_top UUT (
      .dsp_clk (dsp_clk), .por_rst (por_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .adc0_a_i (adc0_a), .adc0_b_i (adc0_b), .adc1_a_i (adc1_a), .adc1_b_i (adc1_b),
      .run_rx0_i (run_rx0), .run_rx1_i (run_rx1), .pps_i (pps),
      .button_i (button), .clk_status_i (clk_status), .rb_addr_i (rb_addr),
      .rx0_i_o (rx0_i), .rx0_q_o (rx0_q), .rx1_i_o (rx1_i), .rx1_q_o (rx1_q),
      .run0_o (run0), .run1_o (run1), .leds_o (leds),
      .div_sw1_o (div_sw1), .div_sw2_o (div_sw2), .phy_reset_n_o (phy_reset_n),
      .pps_int_o (pps_int), .rb_data_o (rb_data)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   function automatic sample_t to_sample(input adc_word_t w);
      return {w, 12'h000};   // ADC word on top
   endfunction

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "run stopped on a mismatch");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////
   assign time_ctrl_wr = set_stb && (set_addr == TIME_BASE + 2);
   assign m_pps_edge   = m_pps_pipe[1] & ~m_pps_pipe[2];

   always @(posedge dsp_clk) begin
      if (por_rst) begin
         m_swap     <= 1'b0;
         m_run0     <= 1'b0;
         m_run1     <= 1'b0;
         m_led_sw   <= 8'h00;
         m_led_src  <= 8'b0001_1110;
         m_div1     <= 1'b1;
         m_div2     <= 1'b1;
         m_phy      <= 1'b0;
         m_time     <= '0;
         m_time_pps <= '0;
         m_pps_pipe <= 3'b000;
         m_pps_int  <= 1'b0;
         m_armed    <= 1'b0;
      end else begin
         if (set_stb) begin
            case (set_addr)
               SR_MISC + 3:    m_led_sw  <= set_data[7:0];
               SR_MISC + 4:    m_phy     <= set_data[0];
               SR_MISC + 6:    m_led_src <= set_data[7:0];
               SR_RX_FRONT_SW: m_swap    <= set_data[0];
               SR_DIVSW:       m_div1    <= set_data[0];
               SR_DIVSW + 1:   m_div2    <= set_data[0];
               TIME_BASE:      m_hi      <= set_data;
               TIME_BASE + 1:  m_lo      <= set_data;
               default: ;
            endcase
         end
         m_run0     <= m_swap ? run_rx1 : run_rx0;   // Run flag follows its channel
         m_run1     <= m_swap ? run_rx0 : run_rx1;
         m_pps_pipe <= {m_pps_pipe[1:0], pps};
         m_pps_int  <= m_pps_edge;
         if (m_pps_int) begin
            m_time_pps <= m_time;
         end
         if (time_ctrl_wr && set_data[0]) begin
            m_time  <= {m_hi, m_lo};
            m_armed <= 1'b0;
         end else if (time_ctrl_wr) begin
            m_time  <= m_time + 1;
            m_armed <= 1'b1;
         end else if (m_armed && m_pps_edge) begin
            m_time  <= {m_hi, m_lo};
            m_armed <= 1'b0;
         end else begin
            m_time <= m_time + 1;
         end
      end
   end

   // Sample registers have no reset
   always @(posedge dsp_clk) begin
      m_rx0_i <= to_sample(m_swap ? adc1_a : adc0_a);
      m_rx0_q <= to_sample(m_swap ? adc1_b : adc0_b);
      m_rx1_i <= to_sample(m_swap ? adc0_a : adc1_a);
      m_rx1_q <= to_sample(m_swap ? adc0_b : adc1_b);
   end

   // Per bit, hardware where the source bit is set, software otherwise
   function automatic logic [7:0] expected_leds();
      logic [7:0] hw;
      logic [7:0] leds_exp;
      hw    = 8'h00;
      hw[3] = m_run0;
      hw[1] = m_run1;
      for (int b = 0; b < 8; b++) begin
         leds_exp[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      end
      return leds_exp;
   endfunction

   function automatic logic [31:0] expected_word(input logic [3:0] addr);
      logic [31:0] status;
      status     = 32'd0;
      status[13] = button;
      status[11] = clk_status;
      case (addr)
         RB_ADC0:    return {m_rx0_i[23:8], m_rx0_q[23:8]};
         RB_ADC1:    return {m_rx1_i[23:8], m_rx1_q[23:8]};
         RB_TIME_HI: return m_time[63:32];
         RB_TIME_LO: return m_time[31:0];
         RB_COMPAT:  return 32'h0008_0002;    // Major 8, minor 2
         RB_STATUS:  return status;
         RB_PPS_HI:  return m_time_pps[63:32];
         RB_PPS_LO:  return m_time_pps[31:0];
         default:    return 32'd0;
      endcase
   endfunction

   // Random ADC words, run flags and status pins
   always @(posedge dsp_clk) begin
      if (stim_on) begin
         stim_rnd = $random(seed);
         adc0_a     <= stim_rnd[11:0];
         adc0_b     <= stim_rnd[23:12];
         run_rx0    <= stim_rnd[24];
         run_rx1    <= stim_rnd[25];
         button     <= stim_rnd[26];
         clk_status <= stim_rnd[27];
         stim_rnd = $random(seed);
         adc1_a     <= stim_rnd[11:0];
         adc1_b     <= stim_rnd[23:12];
      end
   end

   always @(negedge dsp_clk) begin
      if (checking) begin
         check(rx0_i, m_rx0_i, "rx0 I");
         check(rx0_q, m_rx0_q, "rx0 Q");
         check(rx1_i, m_rx1_i, "rx1 I");
         check(rx1_q, m_rx1_q, "rx1 Q");
         check(run0, m_run0, "run0");
         check(run1, m_run1, "run1");
         check(leds, expected_leds(), "leds");
         check(div_sw1, m_div1, "div_sw1");
         check(div_sw2, m_div2, "div_sw2");
         check(phy_reset_n, !m_phy, "phy_reset_n");
         check(pps_int, m_pps_int, "pps_int");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////////////////////////
   task automatic write_reg(input int addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_stb  <= 1'b1;
      set_addr <= set_addr_t'(addr);
      set_data <= data;
      @(posedge dsp_clk);
      set_stb  <= 1'b0;      // Register took the value on this edge
   endtask

   task automatic read_rb(input logic [3:0] addr, output logic [31:0] data);
      logic [31:0] exp;
      @(posedge dsp_clk);
      rb_addr <= addr;
      @(negedge dsp_clk);
      exp = expected_word(addr);   // Sampled by the next edge
      @(negedge dsp_clk);
      data = rb_data;
      check(data, exp, $sformatf("readback word %0d", addr));
   endtask

   task automatic load_time(input vita_time_t value, input logic now);
      write_reg(TIME_BASE, value[63:32]);
      write_reg(TIME_BASE + 1, value[31:0]);
      write_reg(TIME_BASE + 2, {31'd0, now});
   endtask

   initial begin
      logic [31:0] d;
      vita_time_t  load;
      int          idx;
      int          cycles;
      logic        seen;
      int          misc_addr [5];
      misc_addr = '{SR_MISC + 3, SR_MISC + 4, SR_MISC + 6, SR_DIVSW, SR_DIVSW + 1};
      por_rst  = 1'b1;
      checking = 1'b0;
      stim_on  = 1'b0;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      adc0_a   = '0;
      adc0_b   = '0;
      adc1_a   = '0;
      adc1_b   = '0;
      run_rx0  = 1'b0;
      run_rx1  = 1'b0;
      pps      = 1'b0;
      button   = 1'b0;
      clk_status = 1'b0;
      rb_addr  = 4'd0;
      repeat (10) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      check(leds, 8'h00, "leds after reset");
      check(div_sw1, 1'b1, "div_sw1 after reset");
      check(div_sw2, 1'b1, "div_sw2 after reset");
      check(phy_reset_n, 1'b1, "phy_reset_n after reset");
      check(pps_int, 1'b0, "pps_int after reset");
      @(posedge dsp_clk);
      checking <= 1'b1;
      stim_on  <= 1'b1;

      // Front end straight, then swapped
      repeat (20) @(posedge dsp_clk);
      write_reg(SR_RX_FRONT_SW, 32'd1);
      repeat (20) @(posedge dsp_clk);

      // Misc registers against the LED rule
      for (int n = 0; n < 40; n++) begin
         idx = $unsigned($random(seed)) % 5;
         write_reg(misc_addr[idx], $random(seed));
         repeat ($unsigned($random(seed)) % 3) @(posedge dsp_clk);
      end

      //////////////////////////////////////////////////////////////////////
      // Time load now
      //////////////////////////////////////////////////////////////////////
      for (int n = 0; n < 3; n++) begin
         load = {$random(seed), $random(seed)};
         @(posedge dsp_clk);
         rb_addr <= RB_TIME_LO;
         load_time(load, 1'b1);
         @(negedge dsp_clk);
         @(negedge dsp_clk);
         check(rb_data, load[31:0], "time low right after load");
         read_rb(RB_TIME_HI, d);
         read_rb(RB_TIME_LO, d);
      end

      // Load armed for the next PPS edge
      load = {$random(seed), $random(seed)};
      load_time(load, 1'b0);
      @(posedge dsp_clk);
      rb_addr <= RB_TIME_LO;
      pps     <= 1'b1;
      seen   = 1'b0;
      cycles = 0;
      for (int n = 0; n < PPS_TIMEOUT && !seen; n++) begin
         @(negedge dsp_clk);
         if (pps_int) begin
            seen = 1'b1;
         end else begin
            cycles++;
         end
      end
      if (!seen) begin
         $display("timeout: pps_int_o never pulsed after the PPS edge");
         $display("ERRORS FOUND");
         $fatal(1, "no PPS detection");
      end
      check(cycles, 3, "PPS detection latency");   // Two sync flops plus edge flop
      @(negedge dsp_clk);
      check(rb_data, load[31:0], "time low at PPS");
      @(posedge dsp_clk);
      pps <= 1'b0;
      read_rb(RB_PPS_HI, d);
      check(d, load[63:32], "PPS time high");
      read_rb(RB_PPS_LO, d);
      check(d, load[31:0], "PPS time low");

      // Remaining readback words
      for (int n = 0; n < 8; n++) begin
         read_rb(RB_COMPAT, d);
         read_rb(RB_STATUS, d);
         read_rb(RB_ADC0, d);
         read_rb(RB_ADC1, d);
      end
      read_rb(4'd3, d);
      repeat (4) @(posedge dsp_clk);
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- vita_timer.sv
// 64-bit tick counter on dsp_clk; pps_i may be asynchronous and sees three flops of latency
`timescale 1ns/1ps

module vita_timer #(
   parameter int BASE = sdr_regmap_pkg::SR_TIME64
) (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  sdr_types_pkg::set_addr_t  set_addr_i,
   input  sdr_types_pkg::set_data_t  set_data_i,
   input  logic                      pps_i,
   output sdr_types_pkg::vita_time_t time_o,
   output sdr_types_pkg::vita_time_t time_pps_o,
   output logic                      pps_int_o
);
   import sdr_types_pkg::*;
   import sdr_regmap_pkg::*;

   localparam set_addr_t ADDR_HI   = set_addr_t'(BASE + TIME_HI);
   localparam set_addr_t ADDR_LO   = set_addr_t'(BASE + TIME_LO);
   localparam set_addr_t ADDR_CTRL = set_addr_t'(BASE + TIME_CTRL);

   set_data_t  time_hi;
   set_data_t  time_lo;
   time_load_e load_cmd;     // Decoded from this cycle's write
   time_load_e load_state;   // Pending load
   logic [1:0] pps_sync;
   logic       pps_dly;
   logic       pps_rise;

   // Staging words
   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && (set_addr_i == ADDR_HI)) begin
         time_hi <= set_data_i;
      end
      if (set_stb_i && (set_addr_i == ADDR_LO)) begin
         time_lo <= set_data_i;
      end
   end

   always_comb begin
      load_cmd = LOAD_IDLE;
      if (set_stb_i && (set_addr_i == ADDR_CTRL)) begin
         load_cmd = set_data_i[0] ? LOAD_NOW : LOAD_AT_PPS;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // PPS synchronizer and edge detect
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync  <= 2'b00;
         pps_dly   <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_sync  <= {pps_sync[0], pps_i};
         pps_dly   <= pps_sync[1];
         pps_int_o <= pps_rise;   // High in the detection cycle
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_dly;

   // Armed load, a load now cancels a pending one
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         load_state <= LOAD_IDLE;
      end else if (load_cmd == LOAD_NOW) begin
         load_state <= LOAD_IDLE;
      end else if (load_cmd == LOAD_AT_PPS) begin
         load_state <= LOAD_AT_PPS;
      end else if (pps_rise) begin
         load_state <= LOAD_IDLE;
      end
   end

   // Counter and PPS latch
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_o     <= '0;
         time_pps_o <= '0;
      end else begin
         if (load_cmd == LOAD_NOW) begin
            time_o <= {time_hi, time_lo};
         end else if ((load_state == LOAD_AT_PPS) && pps_rise) begin
            time_o <= {time_hi, time_lo};   // Visible together with pps_int_o
         end else begin
            time_o <= time_o + 1'b1;
         end
         if (pps_int_o) begin
            time_pps_o <= time_o;
         end
      end
   end

endmodule
